// ==== src/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`default_nettype none

`define RESET_PC 32'h80000000

// ----------------------------------------------------------
// base opcodes in use
// ----------------------------------------------------------
`define OPC_LUI    7'b0110111
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`define INSTR_WFI   32'h10500073
`define INSTR_ECALL 32'h00000073

// ----------------------------------------------------------
// decoded operation classes
// ----------------------------------------------------------
`define KIND_LUI   4'd0
`define KIND_ADDI  4'd1
`define KIND_ADD   4'd2
`define KIND_SUB   4'd3
`define KIND_LW    4'd4
`define KIND_SW    4'd5
`define KIND_SB    4'd6
`define KIND_BEQ   4'd7
`define KIND_BNE   4'd8
`define KIND_JAL   4'd9
`define KIND_WFI   4'd10
`define KIND_ECALL 4'd11

`default_nettype wire

`endif

// ==== src/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [3:0]  op_kind_t;

    // ----------------------------------------------------------
    // generic bus
    // ----------------------------------------------------------
    typedef struct packed {
        logic     ren;
        logic     wen;
        byte_en_t byte_en;
        word_t    addr;
        word_t    wdata;
    } bus_req_t;

    typedef struct packed {
        logic  busy;
        logic  error;
        word_t rdata;
    } bus_rsp_t;

    // bit 0 is ext, bit 1 is soft, bit 2 is timer in both fields.
    typedef struct packed {
        logic [2:0] req;
        logic [2:0] clr;
    } irq_lines_t;

    // ----------------------------------------------------------
    // decode and control
    // ----------------------------------------------------------
    typedef struct packed {
        op_kind_t  op_kind;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      illegal;
    } decoded_t;

    typedef enum logic [2:0] {
        FETCH,
        EXEC,
        MEM,
        WB,
        SLEEP,
        HALTED
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/bus_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_adapter (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  start,
    input  rv_core_pkg::bus_req_t req,
    input  rv_core_pkg::bus_rsp_t rsp,
    output rv_core_pkg::bus_req_t bus,
    output logic                  done,
    output logic                  error,
    output rv_core_pkg::word_t    rdata
);
    import rv_core_pkg::*;

    logic     ren_q;
    logic     wen_q;
    byte_en_t byte_en_q;
    word_t    addr_q;
    word_t    wdata_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            ren_q <= 1'b0;
            wen_q <= 1'b0;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                ren_q <= req.ren;
                wen_q <= req.wen;
            end else if ((ren_q || wen_q) && !rsp.busy) begin
                ren_q <= 1'b0;                      // transfer is over this cycle.
                wen_q <= 1'b0;
                done  <= 1'b1;
                error <= rsp.error;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            byte_en_q <= req.byte_en;
            addr_q    <= req.addr;
            wdata_q   <= req.wdata;
        end
        if ((ren_q || wen_q) && !rsp.busy) begin
            rdata <= rsp.rdata;
        end
    end

    assign bus = '{ren: ren_q, wen: wen_q, byte_en: byte_en_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// ==== src/interrupt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  rv_core_pkg::irq_lines_t irq,
    output logic                    wake
);

    logic [2:0] pending_q;

    // a clear pulse beats a request arriving in the same cycle.
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 3'b000;
        end else begin
            pending_q <= (pending_q | irq.req) & ~irq.clr;
        end
    end

    assign wake = |pending_q;                       // any pending line ends sleep.

endmodule

`default_nettype wire

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"
`default_nettype none

module instr_decoder (
    input  rv_core_pkg::word_t    instr,
    output rv_core_pkg::decoded_t dec
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ----------------------------------------------------------
    // immediate formats
    // ----------------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.imm     = imm_i;
        dec.op_kind = `KIND_ADDI;
        dec.illegal = 1'b0;
        if (instr == `INSTR_WFI) begin
            dec.op_kind = `KIND_WFI;
        end else if (instr == `INSTR_ECALL) begin
            dec.op_kind = `KIND_ECALL;
        end else begin
            case (opcode)
                `OPC_LUI: begin
                    dec.op_kind = `KIND_LUI;
                    dec.imm     = imm_u;
                end
                `OPC_OPIMM: dec.illegal = (funct3 != 3'b000);
                `OPC_OP: begin
                    if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                        dec.op_kind = `KIND_ADD;
                    end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                        dec.op_kind = `KIND_SUB;
                    end else begin
                        dec.illegal = 1'b1;
                    end
                end
                `OPC_LOAD: begin
                    dec.op_kind = `KIND_LW;
                    dec.illegal = (funct3 != 3'b010);   // only full words are loaded.
                end
                `OPC_STORE: begin
                    dec.imm     = imm_s;
                    dec.op_kind = (funct3 == 3'b000) ? `KIND_SB : `KIND_SW;
                    dec.illegal = (funct3 != 3'b000) && (funct3 != 3'b010);
                end
                `OPC_BRANCH: begin
                    dec.imm     = imm_b;
                    dec.op_kind = (funct3 == 3'b001) ? `KIND_BNE : `KIND_BEQ;
                    dec.illegal = (funct3 != 3'b000) && (funct3 != 3'b001);
                end
                `OPC_JAL: begin
                    dec.op_kind = `KIND_JAL;
                    dec.imm     = imm_j;
                end
                default: dec.illegal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::reg_addr_t rd,
    input  logic                   we,
    input  rv_core_pkg::word_t     wdata,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2
);
    import rv_core_pkg::*;

    word_t regs [31:1];                             // x0 has no storage.

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"
`default_nettype none

module exec_unit (
    input  rv_core_pkg::decoded_t dec,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    op_a,
    input  rv_core_pkg::word_t    op_b,
    output rv_core_pkg::word_t    result,
    output rv_core_pkg::word_t    next_pc,
    output rv_core_pkg::word_t    store_data,
    output rv_core_pkg::byte_en_t store_en
);
    import rv_core_pkg::*;

    word_t pc_plus4;
    word_t target;

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + dec.imm;

    // loads, stores and ADDI all use rs1 plus the immediate.
    always_comb begin
        result  = op_a + dec.imm;
        next_pc = pc_plus4;
        case (dec.op_kind)
            `KIND_LUI: result = dec.imm;
            `KIND_ADD: result = op_a + op_b;
            `KIND_SUB: result = op_a - op_b;
            `KIND_BEQ: next_pc = (op_a == op_b) ? target : pc_plus4;
            `KIND_BNE: next_pc = (op_a != op_b) ? target : pc_plus4;
            `KIND_JAL: begin
                result  = pc_plus4;                 // link address.
                next_pc = target;
            end
            default: result = op_a + dec.imm;
        endcase
    end

    always_comb begin
        if (dec.op_kind == `KIND_SB) begin
            store_data = {4{op_b[7:0]}};
            store_en   = 4'b0001 << result[1:0];
        end else begin
            store_data = op_b;
            store_en   = 4'b1111;
        end
    end

endmodule

`default_nettype wire

// ==== src/core_control.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"
`default_nettype none

module core_control #(
    parameter rv_core_pkg::word_t RESET_PC = `RESET_PC
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  done,
    input  logic                  bus_error,
    input  rv_core_pkg::word_t    rdata,
    input  logic                  wake,
    output logic                  start,
    output rv_core_pkg::bus_req_t req,
    output logic                  wfi,
    output logic                  halt
);
    import rv_core_pkg::*;

    ctrl_state_t state_q;
    word_t       pc_q;
    word_t       ir_q;
    word_t       load_q;
    logic        xfer_q;
    decoded_t    dec;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       result;
    word_t       next_pc;
    word_t       store_data;
    byte_en_t    store_en;
    logic        is_load;
    logic        is_mem;
    logic        rf_we;
    word_t       rf_wdata;

    instr_decoder decoder_i (
        .instr(ir_q),
        .dec  (dec)
    );

    reg_file rf_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .rd    (dec.rd),
        .we    (rf_we),
        .wdata (rf_wdata),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    exec_unit exec_i (
        .dec       (dec),
        .pc        (pc_q),
        .op_a      (rs1_data),
        .op_b      (rs2_data),
        .result    (result),
        .next_pc   (next_pc),
        .store_data(store_data),
        .store_en  (store_en)
    );

    assign is_load  = (dec.op_kind == `KIND_LW);
    assign is_mem   = is_load || dec.op_kind == `KIND_SW || dec.op_kind == `KIND_SB;
    assign rf_we    = (state_q == WB) && (dec.op_kind == `KIND_LUI || dec.op_kind == `KIND_ADDI
                      || dec.op_kind == `KIND_ADD || dec.op_kind == `KIND_SUB
                      || dec.op_kind == `KIND_JAL || is_load);
    assign rf_wdata = is_load ? load_q : result;

    // ----------------------------------------------------------
    // bus requests
    // ----------------------------------------------------------
    assign start = (state_q == FETCH || state_q == MEM) && !xfer_q;

    always_comb begin
        req = '0;
        if (state_q == FETCH) begin
            req.ren     = 1'b1;
            req.byte_en = 4'b1111;
            req.addr    = pc_q;
        end else begin
            req.ren     = is_load;
            req.wen     = !is_load;
            req.byte_en = is_load ? 4'b1111 : store_en;
            req.addr    = {result[31:2], 2'b00};    // lanes select the byte.
            req.wdata   = store_data;
        end
    end

    // ----------------------------------------------------------
    // state machine
    // ----------------------------------------------------------
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FETCH;
            pc_q    <= RESET_PC;
            xfer_q  <= 1'b0;
        end else begin
            if (start) begin
                xfer_q <= 1'b1;
            end else if (done) begin
                xfer_q <= 1'b0;
            end
            case (state_q)
                FETCH: if (done) state_q <= bus_error ? HALTED : EXEC;
                EXEC: begin
                    if (dec.illegal || dec.op_kind == `KIND_ECALL) begin
                        state_q <= HALTED;
                    end else if (dec.op_kind == `KIND_WFI) begin
                        state_q <= SLEEP;
                    end else begin
                        state_q <= is_mem ? MEM : WB;
                    end
                end
                MEM: if (done) state_q <= bus_error ? HALTED : WB;
                WB: begin
                    pc_q    <= next_pc;
                    state_q <= FETCH;
                end
                SLEEP: begin
                    if (wake) begin
                        pc_q    <= next_pc;         // WFI falls through to pc+4.
                        state_q <= FETCH;
                    end
                end
                default: state_q <= HALTED;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (done && state_q == FETCH) begin
            ir_q <= rdata;
        end
        if (done && state_q == MEM) begin
            load_q <= rdata;
        end
    end

    assign wfi  = (state_q == SLEEP);
    assign halt = (state_q == HALTED);

endmodule

`default_nettype wire

// ==== src/top_core.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"
`default_nettype none

module top_core #(
    parameter rv_core_pkg::word_t RESET_PC = `RESET_PC
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic                  error,
    input  rv_core_pkg::word_t    rdata,
    output logic                  ren,
    output logic                  wen,
    output rv_core_pkg::byte_en_t byte_en,
    output rv_core_pkg::word_t    addr,
    output rv_core_pkg::word_t    wdata,
    input  logic                  ext_int,
    input  logic                  ext_int_clear,
    input  logic                  soft_int,
    input  logic                  soft_int_clear,
    input  logic                  timer_int,
    input  logic                  timer_int_clear,
    output logic                  wfi,
    output logic                  halt
);
    import rv_core_pkg::*;

    bus_rsp_t   rsp;
    bus_req_t   bus;
    bus_req_t   core_req;
    irq_lines_t irq;
    logic       start;
    logic       done;
    logic       bus_error;
    logic       wake;
    word_t      xfer_rdata;

    assign rsp = '{busy: busy, error: error, rdata: rdata};
    assign irq = '{req: {timer_int, soft_int, ext_int},
                   clr: {timer_int_clear, soft_int_clear, ext_int_clear}};

    assign ren     = bus.ren;
    assign wen     = bus.wen;
    assign byte_en = bus.byte_en;
    assign addr    = bus.addr;
    assign wdata   = bus.wdata;

    bus_adapter bus_i (
        .CLK  (CLK),
        .rst_n(rst_n),
        .start(start),
        .req  (core_req),
        .rsp  (rsp),
        .bus  (bus),
        .done (done),
        .error(bus_error),
        .rdata(xfer_rdata)
    );

    interrupt_unit irq_i (
        .CLK  (CLK),
        .rst_n(rst_n),
        .irq  (irq),
        .wake (wake)
    );

    core_control #(.RESET_PC(RESET_PC)) ctrl_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .done     (done),
        .bus_error(bus_error),
        .rdata    (xfer_rdata),
        .wake     (wake),
        .start    (start),
        .req      (core_req),
        .wfi      (wfi),
        .halt     (halt)
    );

endmodule

`default_nettype wire

// ==== tests/tb_top_core.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"
`default_nettype none

module tb_top_core;
    import rv_core_pkg::*;

    typedef struct packed {
        logic [1:0] kind;
        word_t      addr;
        byte_en_t   be;
        word_t      data;
        logic [1:0] irq;
    } row_t;

    localparam logic [1:0] K_STORE = 2'd0;
    localparam logic [1:0] K_WFI   = 2'd1;
    localparam logic [1:0] K_HALT  = 2'd2;
    localparam logic [1:0] K_PULSE = 2'd3;

    localparam logic [1:0] IRQ_EXT  = 2'd0;
    localparam logic [1:0] IRQ_SOFT = 2'd1;
    localparam logic [1:0] IRQ_NONE = 2'd3;

    localparam word_t DATA = 32'h80001000;
    localparam word_t X1   = 32'h12345678;
    localparam word_t X2   = 32'hfffffffb;          // minus five.

    logic       clk;
    logic       rst_n;
    logic       busy;
    logic       error;
    word_t      rdata;
    logic       ren;
    logic       wen;
    byte_en_t   byte_en;
    word_t      addr;
    word_t      wdata;
    logic [2:0] irq_req;
    logic [2:0] irq_clr;
    logic       wfi;
    logic       halt;

    word_t       mem [0:2047];                      // 8 KiB from the reset address.
    row_t        rows[$];
    row_t        ev_q[$];
    int          value_errs;
    int          other_errs;
    logic [31:0] rng = 32'hc2851283;
    logic        active;
    int          wait_left;
    bus_req_t    req_now;
    bus_req_t    req_prev;
    logic        held_prev;
    logic        wfi_prev;
    logic        halt_prev;

    top_core dut_i (
        .CLK            (clk),
        .rst_n          (rst_n),
        .busy           (busy),
        .error          (error),
        .rdata          (rdata),
        .ren            (ren),
        .wen            (wen),
        .byte_en        (byte_en),
        .addr           (addr),
        .wdata          (wdata),
        .ext_int        (irq_req[0]),
        .ext_int_clear  (irq_clr[0]),
        .soft_int       (irq_req[1]),
        .soft_int_clear (irq_clr[1]),
        .timer_int      (irq_req[2]),
        .timer_int_clear(irq_clr[2]),
        .wfi            (wfi),
        .halt           (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // instruction encoders and helpers
    // ----------------------------------------------------------
    function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, `OPC_OP};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t read_word(input word_t a);
        if (a[31:13] == 19'h40000) begin
            return mem[a[12:2]];
        end
        return a ^ 32'h5a5aa5a5;
    endfunction

    task automatic load_program(input int which);
        for (int i = 0; i < 2048; i++) begin
            mem[i] = (`RESET_PC + 32'(i) * 32'd4) ^ 32'hc3a55a3c;
        end
        if (which == 1) begin
            mem[0]  = enc_u(20'h80001, 5'd10);
            mem[1]  = enc_u(20'h12345, 5'd1);
            mem[2]  = enc_i(12'h678, 5'd1, 3'd0, 5'd1, `OPC_OPIMM);
            mem[3]  = enc_i(12'hffb, 5'd0, 3'd0, 5'd2, `OPC_OPIMM);
            mem[4]  = enc_r(7'h00, 5'd2, 5'd1, 5'd3);
            mem[5]  = enc_r(7'h20, 5'd2, 5'd1, 5'd4);
            mem[6]  = enc_s(12'd0, 5'd1, 5'd10, 3'd2);
            mem[7]  = enc_s(12'd4, 5'd3, 5'd10, 3'd2);
            mem[8]  = enc_s(12'd8, 5'd4, 5'd10, 3'd2);
            mem[9]  = enc_i(12'd4, 5'd10, 3'd2, 5'd5, `OPC_LOAD);
            mem[10] = enc_i(12'd1, 5'd5, 3'd0, 5'd5, `OPC_OPIMM);
            mem[11] = enc_s(12'd12, 5'd5, 5'd10, 3'd2);
            mem[12] = enc_s(12'd17, 5'd1, 5'd10, 3'd0);     // byte store to lane 1.
            mem[13] = enc_b(13'd8, 5'd3, 5'd3, 3'd0);       // taken so the marker is skipped.
            mem[14] = enc_s(12'd20, 5'd0, 5'd10, 3'd2);
            mem[15] = enc_b(13'd8, 5'd1, 5'd1, 3'd1);       // never taken.
            mem[16] = enc_s(12'd24, 5'd1, 5'd10, 3'd2);
            mem[17] = enc_j(21'd8, 5'd6);
            mem[18] = enc_s(12'd28, 5'd0, 5'd10, 3'd2);
            mem[19] = enc_s(12'd32, 5'd6, 5'd10, 3'd2);
            mem[20] = `INSTR_WFI;
            mem[21] = enc_i(12'h055, 5'd0, 3'd0, 5'd7, `OPC_OPIMM);
            mem[22] = enc_s(12'd36, 5'd7, 5'd10, 3'd2);
            mem[23] = `INSTR_WFI;
            mem[24] = enc_s(12'd40, 5'd7, 5'd10, 3'd2);
            mem[25] = enc_u(20'h90000, 5'd8);
            mem[26] = enc_i(12'd0, 5'd8, 3'd2, 5'd9, `OPC_LOAD);  // hits the error window.
        end else begin
            mem[0] = enc_i(12'h123, 5'd0, 3'd0, 5'd1, `OPC_OPIMM);
            mem[1] = enc_u(20'h80001, 5'd10);
            mem[2] = enc_s(12'd48, 5'd1, 5'd10, 3'd2);
            mem[3] = `INSTR_ECALL;
        end
    endtask

    task automatic add_row(input logic [1:0] kind, input word_t a, input byte_en_t be,
                           input word_t d, input logic [1:0] irq);
        rows.push_back('{kind: kind, addr: a, be: be, data: d, irq: irq});
    endtask

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_be(input string what, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // the memory model drives its outputs 1 ns after the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (ren || wen) begin
            if (!active) begin
                active    = 1'b1;
                rng       = xorshift(rng);
                wait_left = int'(rng & 32'd3);      // zero to three busy cycles.
            end
            busy  = (wait_left != 0);
            if (wait_left != 0) begin
                wait_left--;
            end
            error = (addr[31:8] == 24'h900000);
            rdata = read_word(addr);
        end else begin
            active = 1'b0;
            busy   = 1'b0;
            error  = 1'b0;
        end
    end

    // the bus and event monitor samples in the middle of the cycle.
    always @(negedge clk) begin
        req_now = '{ren: ren, wen: wen, byte_en: byte_en, addr: addr, wdata: wdata};
        if (held_prev && req_now !== req_prev) begin
            other_errs++;
            $display("at %0t the bus request changed while busy was high", $time);
        end
        held_prev = (ren || wen) && busy;
        req_prev  = req_now;
        if (wen && !busy) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b] && addr[31:13] == 19'h40000) begin
                    mem[addr[12:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            ev_q.push_back('{kind: K_STORE, addr: addr, be: byte_en, data: wdata,
                             irq: IRQ_NONE});
        end
        if (wfi && !wfi_prev) begin
            ev_q.push_back('{kind: K_WFI, addr: '0, be: '0, data: '0, irq: IRQ_NONE});
        end
        if (halt && !halt_prev) begin
            ev_q.push_back('{kind: K_HALT, addr: '0, be: '0, data: '0, irq: IRQ_NONE});
        end
        wfi_prev  = wfi;
        halt_prev = halt;
    end

    // ----------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        ev_q.delete();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_flag("ren right after reset", ren, 1'b0);
        check_flag("halt after reset", halt, 1'b0);
        check_flag("wfi after reset", wfi, 1'b0);
        @(negedge clk);
        check_flag("ren one cycle after reset", ren, 1'b1);  // first fetch.
    endtask

    task automatic pulse_irq(input logic [1:0] line, input logic clear);
        @(posedge clk);
        #1;
        if (clear) begin
            irq_clr[line] = 1'b1;
        end else begin
            irq_req[line] = 1'b1;
        end
        @(posedge clk);
        #1;
        irq_req = 3'b000;
        irq_clr = 3'b000;
    endtask

    task automatic wait_wfi_low(input int limit, input string why);
        int n;
        n = 0;
        while (wfi && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (wfi) begin
            other_errs++;
            $display("at %0t wfi stayed high, %s", $time, why);
        end
    endtask

    task automatic next_event(output row_t ev);
        while (ev_q.size() == 0) begin
            @(negedge clk);
        end
        ev = ev_q.pop_front();
    endtask

    task automatic run_row(input int idx, input row_t row);
        row_t ev;
        if (row.kind == K_PULSE) begin
            pulse_irq(row.irq, 1'b0);
            return;
        end
        next_event(ev);
        if (ev.kind != row.kind) begin
            other_errs++;
            $display("at %0t row %0d expected event kind %0d but the core gave kind %0d",
                     $time, idx, row.kind, ev.kind);
            return;
        end
        if (row.kind == K_STORE) begin
            check_word("store address", ev.addr, row.addr);
            check_be("store byte_en", ev.be, row.be);
            check_word("store data", ev.data, row.data);
        end else if (row.kind == K_WFI && row.irq != IRQ_NONE) begin
            repeat (4) begin
                @(negedge clk);
                check_flag("ren while asleep", ren, 1'b0);
                check_flag("wfi while asleep", wfi, 1'b1);
            end
            pulse_irq(row.irq, 1'b0);
            wait_wfi_low(8, "the interrupt did not wake the core");
            pulse_irq(row.irq, 1'b1);
        end else if (row.kind == K_WFI) begin
            wait_wfi_low(4, "a pending interrupt did not make WFI fall through");
        end else begin
            repeat (10) begin
                @(negedge clk);
                check_flag("ren after halt", ren, 1'b0);
                check_flag("wen after halt", wen, 1'b0);
                check_flag("halt held", halt, 1'b1);
            end
        end
    endtask

    initial begin
        #2;
        repeat (rows.size() * 60) @(posedge clk);
        $display("watchdog expired before the expectation table was finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int prog_no;
        rst_n      = 1'b0;
        busy       = 1'b0;
        error      = 1'b0;
        rdata      = '0;
        irq_req    = 3'b000;
        irq_clr    = 3'b000;
        value_errs = 0;
        other_errs = 0;
        active     = 1'b0;
        wait_left  = 0;
        held_prev  = 1'b0;
        wfi_prev   = 1'b0;
        halt_prev  = 1'b0;

        // first program.
        add_row(K_STORE, DATA + 32'd0, 4'b1111, X1, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd4, 4'b1111, X1 + X2, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd8, 4'b1111, X1 - X2, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd12, 4'b1111, X1 + X2 + 32'd1, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd16, 4'b0010, {4{X1[7:0]}}, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd24, 4'b1111, X1, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd32, 4'b1111, `RESET_PC + 32'd17 * 32'd4 + 32'd4, IRQ_NONE);
        add_row(K_WFI, '0, '0, '0, IRQ_EXT);
        add_row(K_STORE, DATA + 32'd36, 4'b1111, 32'h55, IRQ_NONE);
        add_row(K_PULSE, '0, '0, '0, IRQ_SOFT);
        add_row(K_WFI, '0, '0, '0, IRQ_NONE);
        add_row(K_STORE, DATA + 32'd40, 4'b1111, 32'h55, IRQ_NONE);
        add_row(K_HALT, '0, '0, '0, IRQ_NONE);
        // the second program ends in ECALL.
        add_row(K_STORE, DATA + 32'd48, 4'b1111, 32'h123, IRQ_NONE);
        add_row(K_HALT, '0, '0, '0, IRQ_NONE);

        prog_no = 1;
        load_program(prog_no);
        apply_reset();
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, rows[i]);
            if (rows[i].kind == K_HALT && i < rows.size() - 1) begin
                prog_no++;
                load_program(prog_no);
                apply_reset();
            end
        end

        $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/rv_core_pkg.sv
src/bus_adapter.sv
src/interrupt_unit.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/core_control.sv
src/top_core.sv
tests/tb_top_core.sv

// ==== Makefile ====
TOP := tb_top_core

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f list.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
